/* source/qsnd_bus_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// sound CPU register map, register-select and APB state enums,
// APB request and response structs
////////////////////////////////////////////////////////////////////////////

package qsnd_bus_pkg;

    // paddr[15:12] page codes
    localparam logic [3:0] ram_page_lo = 4'hc;
    localparam logic [3:0] ram_page_hi = 4'hf;
    localparam logic [3:0] reg_page    = 4'hd;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [7:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [7:0] prdata;
        logic       pready;
        logic       pslverr;
    } apb_rsp_t;

    // offsets inside the 0xd000 page
    typedef enum logic [2:0] {
        cmd_lo   = 3'd0,
        cmd_mid  = 3'd1,
        cmd_hi   = 3'd2,   // last byte, raises the DSP interrupt
        ctrl     = 3'd3,   // bank in 3:0, DSP run in 7
        tick_ack = 3'd4,
        status   = 3'd7
    } qsnd_reg_e;

    typedef enum logic [1:0] {idle, setup, access, wait_st} apb_state_e;

endpackage

/* source/qsnd_dsp_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// DSP parallel port, serial port and audio output structs
////////////////////////////////////////////////////////////////////////////

package qsnd_dsp_pkg;

    // parallel side, driven by the DSP
    typedef struct packed {
        logic        pods_n;    // output data strobe
        logic        pids_n;    // input data strobe
        logic        iack;      // interrupt acknowledge
        logic [15:0] pbus_out;
        logic [6:0]  ab_hi;     // address bus bits that reach the sample ROM
    } dsp_pio_t;

    // serial output pins
    typedef struct packed {
        logic ock;     // bit clock, data valid on the falling edge
        logic sdo;
        logic psel;    // low for left, high for right
        logic sadd;
    } dsp_ser_t;

    // one stereo sample, sample pulses when both words are new
    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
        logic               sample;
    } audio_t;

endpackage

/* source/qsnd_cmd_regs.sv */
////////////////////////////////////////////////////////////////////////////
// sound CPU register page: command latch, bank and control, status byte
// and the DSP interrupt handshake
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module qsnd_cmd_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  qsnd_bus_pkg::apb_req_t req,
    input  logic                   sel,
    input  qsnd_dsp_pkg::dsp_pio_t pio,
    output qsnd_bus_pkg::apb_rsp_t rsp,
    output logic [15:0]            pbus_in,
    output logic                   dsp_irq,
    output logic                   dsp_rst,
    output logic [3:0]             bank,
    output logic                   tick_ack
);

qsnd_bus_pkg::apb_state_e  phase;
qsnd_bus_pkg::qsnd_reg_e   reg_sel;
logic [23:0]               cmd_q;      // command word for the DSP
logic                      reg_hit;
logic                      done;
logic                      wr_en;
logic                      hi_wr;
logic                      pids_q;
logic                      pids_rise;
logic                      ready_n;
logic [7:0]                status_byte;

// bus phase straight from the pins, every access ends in its first cycle
assign phase = !req.psel    ? qsnd_bus_pkg::idle :
               !req.penable ? qsnd_bus_pkg::setup : qsnd_bus_pkg::access;

assign reg_hit = req.paddr[15:12] == qsnd_bus_pkg::reg_page;
assign reg_sel = qsnd_bus_pkg::qsnd_reg_e'(req.paddr[2:0]);
assign done    = sel && phase == qsnd_bus_pkg::access;
assign wr_en   = done && reg_hit && req.pwrite;
assign hi_wr   = wr_en && reg_sel == qsnd_bus_pkg::cmd_hi;

assign tick_ack  = wr_en && reg_sel == qsnd_bus_pkg::tick_ack;  // one-cycle pulse
assign pids_rise = pio.pids_n && !pids_q;

// DSP may still be busy with the previous word while iack is up
assign ready_n     = ~(dsp_irq | pio.iack);
assign status_byte = {ready_n, 3'b111, bank};

always_comb begin
    rsp = '0;
    if (done) begin
        rsp.pready  = 1'b1;
        rsp.pslverr = !reg_hit;          // unmapped page
        if (reg_hit && !req.pwrite) begin
            rsp.prdata = reg_sel == qsnd_bus_pkg::status ? status_byte : 8'hff;
        end
    end
end

always_ff @(posedge clk) begin
    if (wr_en) begin
        case (reg_sel)
            qsnd_bus_pkg::cmd_lo:  cmd_q[7:0]   <= req.pwdata;
            qsnd_bus_pkg::cmd_mid: cmd_q[15:8]  <= req.pwdata;
            qsnd_bus_pkg::cmd_hi:  cmd_q[23:16] <= req.pwdata;
            default: ;
        endcase
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        bank    <= 4'd0;
        dsp_rst <= 1'b1;    // DSP held until the CPU lets it run
        dsp_irq <= 1'b0;
        pids_q  <= 1'b1;
    end else begin
        pids_q <= pio.pids_n;
        if (wr_en && reg_sel == qsnd_bus_pkg::ctrl) begin
            bank    <= req.pwdata[3:0];
            dsp_rst <= ~req.pwdata[7];
        end
        if (hi_wr)
            dsp_irq <= 1'b1;      // new command pending
        else if (pids_rise)
            dsp_irq <= 1'b0;      // DSP has taken the top byte
    end
end

// DSP reads the top byte first, then the low word once irq is down
always_comb begin
    if (pio.pods_n)
        pbus_in = 16'hffff;
    else if (dsp_irq)
        pbus_in = {8'd0, cmd_q[23:16]};
    else
        pbus_in = cmd_q[15:0];
end

// the DSP never reads and writes the parallel port at once
strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
    pio.pods_n || pio.pids_n)
    else $error("DSP drove pods_n and pids_n low together");

ready_after_setup: assert property (@(posedge clk) disable iff (rst)
    rsp.pready |-> req.penable && $past(req.psel && !req.penable))
    else $error("pready outside the first access cycle");

endmodule

/* source/qsnd_serial_rx.sv */
////////////////////////////////////////////////////////////////////////////
// serial audio deserializer and sample ROM address latch
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module qsnd_serial_rx (
    input  logic                   clk,
    input  logic                   rst,
    input  qsnd_dsp_pkg::dsp_ser_t ser,
    input  qsnd_dsp_pkg::dsp_pio_t pio,
    output qsnd_dsp_pkg::audio_t   audio,
    output logic [22:0]            qsnd_addr
);

logic        ock_q;
logic        psel_q;
logic        pods_q;
logic [15:0] left_sr;
logic [15:0] right_sr;
logic        ock_fall;
logic        psel_rise;
logic        pods_rise;

assign ock_fall  = !ser.ock && ock_q;
assign psel_rise = ser.psel && !psel_q;
assign pods_rise = pio.pods_n && !pods_q;

// shift registers, MSB first
always_ff @(posedge clk) begin
    if (ock_fall) begin
        if (!ser.psel)
            left_sr  <= {left_sr[14:0], ser.sdo};
        else
            right_sr <= {right_sr[14:0], ser.sdo};
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        ock_q     <= 1'b0;
        psel_q    <= 1'b1;    // no false edge out of reset
        pods_q    <= 1'b1;
        audio     <= '0;
        qsnd_addr <= 23'd0;
    end else begin
        ock_q  <= ser.ock;
        psel_q <= ser.psel;
        pods_q <= pio.pods_n;
        audio.sample <= psel_rise;
        if (psel_rise) begin
            audio.left  <= left_sr;
            audio.right <= right_sr;
        end
        if (pods_rise) qsnd_addr[15:0] <= pio.pbus_out;   // low address word
        qsnd_addr[22:16] <= pio.ab_hi;
    end
end

// a bit is never clocked in the cycle the channel select moves
psel_stable_on_bit: assert property (@(posedge clk) disable iff (rst)
    ock_fall |-> ser.psel == psel_q)
    else $error("psel changed on an ock falling edge");

endmodule

/* source/qsnd_tick_irq.sv */
////////////////////////////////////////////////////////////////////////////
// periodic sound CPU interrupt with acknowledge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module qsnd_tick_irq #(
    parameter int TICK_PERIOD = 32000
) (
    input  logic clk,
    input  logic rst,
    input  logic ack,
    output logic int_n
);

localparam int CW = (TICK_PERIOD > 1) ? $clog2(TICK_PERIOD) : 1;

logic [CW-1:0] cnt;
logic          wrap;

assign wrap = cnt == CW'(TICK_PERIOD - 1);

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        cnt   <= '0;
        int_n <= 1'b1;
    end else begin
        cnt <= wrap ? '0 : cnt + 1'b1;     // free-running
        if (ack)
            int_n <= 1'b1;    // ack wins over a wrap in the same cycle
        else if (wrap)
            int_n <= 1'b0;
    end
end

endmodule

/* source/qsnd_shared_ram.sv */
////////////////////////////////////////////////////////////////////////////
// dual-port RAM shared by the sound CPU and the host, host bus lock
// and APB wait control for both ports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module qsnd_shared_ram #(
    parameter int RAM_AW = 13
) (
    input  logic                   clk,
    input  logic                   rst,
    input  qsnd_bus_pkg::apb_req_t snd_req,
    input  logic                   snd_sel,
    input  qsnd_bus_pkg::apb_req_t host_req,
    output qsnd_bus_pkg::apb_rsp_t snd_rsp,
    output qsnd_bus_pkg::apb_rsp_t host_rsp
);

logic [7:0]               mem [2**RAM_AW];
qsnd_bus_pkg::apb_state_e snd_st;
qsnd_bus_pkg::apb_state_e host_st;
logic [1:0]               lock;        // request shift, lock[1] is the grant
logic                     grant;
logic                     snd_setup;
logic                     host_setup;
logic                     snd_busy;
logic                     snd_go;
logic                     host_go;
logic [RAM_AW-1:0]        snd_addr;
logic [RAM_AW-1:0]        host_addr;
logic [7:0]               snd_rd;
logic [7:0]               host_rd;

// access -> wait once the port may touch the RAM
function automatic qsnd_bus_pkg::apb_state_e step(qsnd_bus_pkg::apb_state_e st,
                                                  logic start, logic go);
    case (st)
        qsnd_bus_pkg::idle:   step = start ? qsnd_bus_pkg::access : qsnd_bus_pkg::idle;
        qsnd_bus_pkg::access: step = go ? qsnd_bus_pkg::wait_st : qsnd_bus_pkg::access;
        default:              step = qsnd_bus_pkg::idle;
    endcase
endfunction

assign grant      = lock[1];
assign snd_setup  = snd_sel && snd_req.psel && !snd_req.penable;
assign host_setup = host_req.psel && !host_req.penable;
assign snd_busy   = snd_setup || snd_st != qsnd_bus_pkg::idle;
assign snd_go     = snd_st == qsnd_bus_pkg::access && !grant;
assign host_go    = host_st == qsnd_bus_pkg::access && grant;
assign snd_addr   = snd_req.paddr[RAM_AW-1:0];
assign host_addr  = host_req.paddr[RAM_AW-1:0];

// lock enters only between sound transfers and drops with host psel
always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        lock    <= 2'b00;
        snd_st  <= qsnd_bus_pkg::idle;
        host_st <= qsnd_bus_pkg::idle;
    end else begin
        lock    <= host_req.psel ? {lock[0], lock[0] | !snd_busy} : 2'b00;
        snd_st  <= step(snd_st, snd_setup, !grant);
        host_st <= step(host_st, host_setup, grant);
    end
end

always_ff @(posedge clk) begin
    if (snd_go) begin
        if (snd_req.pwrite) mem[snd_addr] <= snd_req.pwdata;
        snd_rd <= mem[snd_addr];
    end
    if (host_go) begin
        if (host_req.pwrite) mem[host_addr] <= host_req.pwdata;
        host_rd <= mem[host_addr];
    end
end

always_comb begin
    snd_rsp  = '0;
    host_rsp = '0;
    if (snd_st == qsnd_bus_pkg::wait_st) begin
        snd_rsp.pready = 1'b1;
        snd_rsp.prdata = snd_rd;
    end
    if (host_st == qsnd_bus_pkg::wait_st) begin
        host_rsp.pready = 1'b1;
        host_rsp.prdata = host_rd;
    end
end

snd_stalled_by_lock: assert property (@(posedge clk) disable iff (rst)
    grant |-> !snd_rsp.pready)
    else $error("sound RAM access completed while the host holds the lock");

endmodule

/* source/qsnd_sound_top.sv */
////////////////////////////////////////////////////////////////////////////
// sound glue top: page decode for the sound CPU port, register page,
// shared RAM, serial audio receiver and tick interrupt
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module qsnd_sound_top #(
    parameter int TICK_PERIOD = 32000,
    parameter int RAM_AW      = 13
) (
    input  logic                   clk,
    input  logic                   rst,
    input  qsnd_bus_pkg::apb_req_t snd_req,
    output qsnd_bus_pkg::apb_rsp_t snd_rsp,
    input  qsnd_bus_pkg::apb_req_t host_req,
    output qsnd_bus_pkg::apb_rsp_t host_rsp,
    input  qsnd_dsp_pkg::dsp_pio_t pio_in,
    input  qsnd_dsp_pkg::dsp_ser_t ser_in,
    output logic [15:0]            pbus_in,
    output logic                   dsp_irq,
    output logic                   dsp_rst,
    output logic [22:0]            qsnd_addr,
    output logic [3:0]             bank,
    output logic                   int_n,
    output qsnd_dsp_pkg::audio_t   audio
);

qsnd_bus_pkg::apb_rsp_t cmd_rsp;
qsnd_bus_pkg::apb_rsp_t ram_rsp;
logic [3:0]             page;
logic                   ram_hit;
logic                   tick_ack;

assign page    = snd_req.paddr[15:12];
assign ram_hit = page == qsnd_bus_pkg::ram_page_lo || page == qsnd_bus_pkg::ram_page_hi;

// register block also answers unmapped pages with an error
assign snd_rsp = qsnd_bus_pkg::apb_rsp_t'(cmd_rsp | ram_rsp);

qsnd_cmd_regs u_cmd_regs (
    .clk      (clk),
    .rst      (rst),
    .req      (snd_req),
    .sel      (!ram_hit),
    .pio      (pio_in),
    .rsp      (cmd_rsp),
    .pbus_in  (pbus_in),
    .dsp_irq  (dsp_irq),
    .dsp_rst  (dsp_rst),
    .bank     (bank),
    .tick_ack (tick_ack)
);

qsnd_shared_ram #(.RAM_AW(RAM_AW)) u_shared_ram (
    .clk      (clk),
    .rst      (rst),
    .snd_req  (snd_req),
    .snd_sel  (ram_hit),
    .host_req (host_req),
    .snd_rsp  (ram_rsp),
    .host_rsp (host_rsp)
);

qsnd_serial_rx u_serial_rx (
    .clk       (clk),
    .rst       (rst),
    .ser       (ser_in),
    .pio       (pio_in),
    .audio     (audio),
    .qsnd_addr (qsnd_addr)
);

qsnd_tick_irq #(.TICK_PERIOD(TICK_PERIOD)) u_tick_irq (
    .clk   (clk),
    .rst   (rst),
    .ack   (tick_ack),
    .int_n (int_n)
);

endmodule

/* verif/tb_qsnd_sound.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the sound glue top: file-driven APB and DSP stimulus,
// DSP pin model, value checks and watchdog
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_qsnd_sound;

logic                   clk = 1'b0;
logic                   rst;
qsnd_bus_pkg::apb_req_t snd_req;
qsnd_bus_pkg::apb_rsp_t snd_rsp;
qsnd_bus_pkg::apb_req_t host_req;
qsnd_bus_pkg::apb_rsp_t host_rsp;
qsnd_dsp_pkg::dsp_pio_t pio_in;
qsnd_dsp_pkg::dsp_ser_t ser_in;
logic [15:0]            pbus_in;
logic                   dsp_irq;
logic                   dsp_rst;
logic [22:0]            qsnd_addr;
logic [3:0]             bank;
logic                   int_n;
qsnd_dsp_pkg::audio_t   audio;

string       op_q[$];
logic [31:0] addr_q[$];
logic [31:0] data_q[$];
logic [31:0] exp_q[$];
int          n_ops = 0;
int          n_checks = 0;
int          n_errors = 0;
int          cyc;                   // cycles since reset release
int          last_fall = 0;
logic [31:0] lfsr = 32'h0532_1b69;

always #20 clk = ~clk;

always @(posedge clk or posedge rst) begin
    if (rst)
        cyc <= 0;
    else
        cyc <= cyc + 1;
end

qsnd_sound_top #(.TICK_PERIOD(64), .RAM_AW(13)) dut (
    .clk       (clk),
    .rst       (rst),
    .snd_req   (snd_req),
    .snd_rsp   (snd_rsp),
    .host_req  (host_req),
    .host_rsp  (host_rsp),
    .pio_in    (pio_in),
    .ser_in    (ser_in),
    .pbus_in   (pbus_in),
    .dsp_irq   (dsp_irq),
    .dsp_rst   (dsp_rst),
    .qsnd_addr (qsnd_addr),
    .bank      (bank),
    .int_n     (int_n),
    .audio     (audio)
);

function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// one LFSR step per bit
function automatic logic [15:0] next_audio_word();
    logic [15:0] w;
    w = '0;
    for (int i = 0; i < 16; i++) begin
        lfsr = lfsr_next(lfsr);
        w = {w[14:0], lfsr[0]};
    end
    return w;
endfunction

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    value_ok: assert (got === exp)
        else begin
            n_errors++;
            $display("[FAIL] time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
endtask

task automatic apb_xfer(input logic host, input logic wr, input logic [15:0] addr,
                        input logic [7:0] wdata, output logic [7:0] rdata, output logic err);
    qsnd_bus_pkg::apb_req_t r;
    qsnd_bus_pkg::apb_rsp_t s;
    r = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    if (host)
        host_req <= r;
    else
        snd_req <= r;
    r.penable = 1'b1;
    @(posedge clk);
    if (host)
        host_req <= r;
    else
        snd_req <= r;
    do begin
        @(negedge clk);
        s = host ? host_rsp : snd_rsp;
    end while (!s.pready);
    rdata = s.prdata;
    err   = s.pslverr;
    @(posedge clk);
    if (host)
        host_req <= '0;
    else
        snd_req <= '0;
endtask

// mode 0 holds pods_n low for a peek, mode 1 pulses pids_n
task automatic pulse_dsp_strobe(input logic [31:0] mode, input logic [31:0] irq_exp,
                                input logic [31:0] pbus_exp);
    @(posedge clk);
    if (mode == 0) begin
        pio_in.pods_n <= 1'b0;
    end else begin
        pio_in.pids_n <= 1'b0;
        @(posedge clk);
        pio_in.pids_n <= 1'b1;
        repeat (2) @(posedge clk);
    end
    @(negedge clk);
    check_value(dsp_irq, irq_exp, "dsp_irq");
    check_value(pbus_in, pbus_exp, "pbus_in");
    @(posedge clk);
    pio_in.pods_n <= 1'b1;
endtask

task automatic shift_word(input logic [15:0] w);
    for (int i = 15; i >= 0; i--) begin
        @(posedge clk);
        ser_in.sdo <= w[i];
        ser_in.ock <= 1'b1;
        @(posedge clk);
        ser_in.ock <= 1'b0;        // DUT takes the bit on this fall
    end
endtask

task automatic send_audio(input logic [31:0] pulses_exp);
    logic [15:0] lw;
    logic [15:0] rw;
    int          pulses;
    int          waited;
    lw = next_audio_word();
    rw = next_audio_word();
    shift_word(rw);                // psel is already high
    @(posedge clk);
    ser_in.psel <= 1'b0;
    shift_word(lw);
    @(posedge clk);
    ser_in.psel <= 1'b1;
    pulses = 0;
    waited = 0;
    do begin
        @(negedge clk);
        waited++;
    end while (!audio.sample && waited < 8);
    n_checks++;
    sample_seen: assert (audio.sample)
        else begin
            n_errors++;
            $display("sample strobe did not come after psel rose");
        end
    while (audio.sample && pulses < 4) begin
        pulses++;
        check_value($unsigned(audio.left), lw, "audio.left");
        check_value($unsigned(audio.right), rw, "audio.right");
        @(negedge clk);
    end
    check_value(pulses, pulses_exp, "sample cycles");
endtask

task automatic load_rom_addr(input logic [31:0] ab, input logic [31:0] word,
                             input logic [31:0] exp);
    @(posedge clk);
    pio_in.ab_hi    <= ab[6:0];
    pio_in.pbus_out <= word[15:0];
    pio_in.pods_n   <= 1'b0;
    @(posedge clk);
    pio_in.pods_n <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value(qsnd_addr, exp, "qsnd_addr");
endtask

task automatic wait_tick(input logic [31:0] limit, input logic [31:0] level,
                         input logic [31:0] period);
    @(negedge clk);
    if (level != 0) begin
        check_value(int_n, 1, "int_n after acknowledge");
    end else begin
        while (int_n)
            @(negedge clk);
        if (period == 0) begin
            n_checks++;
            tick_in_time: assert (cyc <= limit)
                else begin
                    n_errors++;
                    $display("[FAIL] time %0t: int_n fell at cycle %0d, limit %0d",
                             $time, cyc, limit);
                end
        end else begin
            check_value(cyc - last_fall, period, "tick period");
        end
        last_fall = cyc;
    end
endtask

initial begin
    int          fd;
    int          code;
    string       line;
    string       op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    logic [7:0]  rdata;
    logic        err;
    rst      = 1'b1;
    snd_req  = '0;
    host_req = '0;
    pio_in   = '{pods_n: 1'b1, pids_n: 1'b1, iack: 1'b0, pbus_out: 16'h0, ab_hi: 7'h0};
    ser_in   = '{ock: 1'b0, sdo: 1'b0, psel: 1'b1, sadd: 1'b0};
    fd = $fopen("verif/qsnd_input.txt", "r");
    if (fd == 0) begin
        n_errors++;
        $display("cannot open the stimulus file verif/qsnd_input.txt");
    end
    while (fd != 0 && !$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code != 0 && line.len() > 0 && line[0] != "#") begin
            if ($sscanf(line, "%s %h %h %h", op, a, d, e) == 4) begin
                op_q.push_back(op);
                addr_q.push_back(a);
                data_q.push_back(d);
                exp_q.push_back(e);
            end
        end
    end
    if (fd != 0)
        $fclose(fd);
    n_ops = op_q.size();
    if (n_ops == 0) begin
        n_errors++;
        $display("no operations found in the stimulus file");
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_ops; i++) begin
        a = addr_q[i];
        d = data_q[i];
        e = exp_q[i];
        if (op_q[i] == "snd_wr" || op_q[i] == "host_wr") begin
            apb_xfer(op_q[i] == "host_wr", 1'b1, a[15:0], d[7:0], rdata, err);
            check_value(err, e, {op_q[i], " pslverr"});
            if (op_q[i] == "snd_wr" && a[15:12] == 4'hd && a[2:0] == 3'd3) begin
                @(negedge clk);                      // ctrl byte
                check_value(bank, d[3:0], "bank");
                check_value(dsp_rst, !d[7], "dsp_rst");
            end
        end else if (op_q[i] == "snd_rd" || op_q[i] == "host_rd") begin
            apb_xfer(op_q[i] == "host_rd", 1'b0, a[15:0], 8'h00, rdata, err);
            check_value(rdata, e, {op_q[i], " read data"});
            check_value(err, 0, {op_q[i], " pslverr"});
        end else if (op_q[i] == "dsp_strobe") begin
            pulse_dsp_strobe(a, d, e);
        end else if (op_q[i] == "dsp_serial") begin
            send_audio(e);
        end else if (op_q[i] == "dsp_addr") begin
            load_rom_addr(a, d, e);
        end else if (op_q[i] == "tick_wait") begin
            wait_tick(a, d, e);
        end else begin
            n_errors++;
            $display("unknown operation %s on stimulus line %0d", op_q[i], i + 1);
        end
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
        $display("Test completed successfully");
    else
        $display("Test failed");
    $finish;
end

// watchdog, 200 cycles per stimulus line
initial begin
    wait (n_ops != 0);
    repeat (n_ops * 200) @(posedge clk);
    $display("timeout: operations did not finish within %0d cycles", n_ops * 200);
    $display("Test failed");
    $finish;
end

endmodule

/* verif/qsnd_input.txt */
# op addr data expected, all hex; writes expect pslverr, reads expect read data
# dsp_strobe mode irq pbus, dsp_serial - - pulses, dsp_addr ab_hi pbus addr, tick_wait limit high period
tick_wait   0042  0000  0000
snd_wr      d004  00    0
tick_wait   0000  0001  0000
tick_wait   0042  0000  0040
snd_wr      d004  00    0
tick_wait   0000  0001  0000
snd_wr      d000  34    0
snd_wr      d001  12    0
snd_wr      d002  5a    0
snd_rd      d007  00    70
dsp_strobe  0     1     005a
dsp_strobe  1     0     ffff
dsp_strobe  0     0     1234
snd_wr      d000  cd    0
snd_wr      d001  ab    0
snd_wr      d002  e1    0
dsp_strobe  0     1     00e1
dsp_strobe  1     0     ffff
dsp_strobe  0     0     abcd
snd_wr      d003  85    0
snd_rd      d007  00    f5
snd_wr      d003  0a    0
snd_rd      d007  00    fa
host_wr     0010  55    0
snd_rd      c010  00    55
host_wr     1ffe  a7    0
snd_rd      fffe  00    a7
snd_wr      c123  3c    0
host_rd     0123  00    3c
snd_wr      f456  c9    0
host_rd     1456  00    c9
snd_wr      8000  11    1
snd_wr      e000  22    1
dsp_serial  0     0     1
dsp_serial  0     0     1
dsp_addr    5a    1234  5a1234
dsp_addr    7f    ffff  7fffff
dsp_addr    01    abcd  01abcd

/* tb.f */
source/qsnd_bus_pkg.sv
source/qsnd_dsp_pkg.sv
source/qsnd_cmd_regs.sv
source/qsnd_serial_rx.sv
source/qsnd_tick_irq.sv
source/qsnd_shared_ram.sv
source/qsnd_sound_top.sv
verif/tb_qsnd_sound.sv

/* Bender.yml */
package:
  name: qsnd_sound

sources:
  - source/qsnd_bus_pkg.sv
  - source/qsnd_dsp_pkg.sv
  - source/qsnd_cmd_regs.sv
  - source/qsnd_serial_rx.sv
  - source/qsnd_tick_irq.sv
  - source/qsnd_shared_ram.sv
  - source/qsnd_sound_top.sv
  - target: test
    files:
      - verif/tb_qsnd_sound.sv
